//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_husky_capture
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/capture_fifo.sv
module capture_fifo
   import capture_pkg::*;
(
   input  logic                  clk_usb_buf,
   input  logic                  rst_n_i,
   input  logic                  push_i,
   input  fifo_word_t            push_word_i,
   input  logic                  pop_i,
   input  logic                  flush_i,
   output fifo_word_t            head_word_o,
   output logic [FIFO_CNT_W-1:0] count_o,
   output logic                  empty_o,
   output logic                  full_o
);

   fifo_word_t            mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] cnt;
   logic                  do_push;
   logic                  do_pop;

   // Flush overrides both sides
   assign do_push = push_i && !full_o && !flush_i;
   assign do_pop  = pop_i && !empty_o && !flush_i;   // Pop on empty ignored

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else if (flush_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at FIFO_DEPTH
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         cnt <= cnt + FIFO_CNT_W'(do_push) - FIFO_CNT_W'(do_pop);
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (do_push) begin
         mem[wr_ptr] <= push_word_i;
      end
   end

   // Head word valid only while not empty
   assign head_word_o = mem[rd_ptr];
   assign count_o     = cnt;
   assign empty_o     = (cnt == '0);
   assign full_o      = (cnt == FIFO_CNT_W'(FIFO_DEPTH));

endmodule

//--- hw/capture_packer.sv
module capture_packer
   import capture_pkg::*;
(
   input  logic                clk_usb_buf,
   input  logic                rst_n_i,
   input  logic                arm_i,
   input  logic [SAMPLE_W-1:0] sample_i,
   input  logic                sample_valid_i,
   input  logic                full_i,
   output logic                push_o,
   output fifo_word_t          push_word_o,
   output logic                sample_lost_o
);

   fifo_word_t        stage_word;   // Sample waiting for its push slot
   logic              stage_vld;
   logic [LOST_W-1:0] lost_cnt;
   logic              mark;
   fifo_word_t        mark_word;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stage_vld <= 1'b0;
      end else begin
         stage_vld <= arm_i && sample_valid_i;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      stage_word.sample_view.cmd    <= CMD_SAMPLE;
      stage_word.sample_view.rsvd   <= '0;
      stage_word.sample_view.sample <= sample_i;
   end

   always_comb begin
      mark_word.overflow_view.cmd  = CMD_OVERFLOW;
      mark_word.overflow_view.lost = lost_cnt;
   end

   // Marker goes out as soon as there is room again
   assign mark          = !full_i && (lost_cnt != '0);
   assign sample_lost_o = stage_vld && (full_i || mark);   // Marker wins the slot
   assign push_o        = !full_i && (mark || stage_vld);
   assign push_word_o   = mark ? mark_word : stage_word;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         lost_cnt <= '0;
      end else if (mark) begin
         // A sample displaced by the marker starts the next count
         lost_cnt <= LOST_W'(sample_lost_o);
      end else if (sample_lost_o && (lost_cnt != LOST_MAX)) begin
         lost_cnt <= lost_cnt + 1'b1;   // Saturates at LOST_MAX
      end
   end

endmodule

//--- hw/capture_pkg.sv
package capture_pkg;

   localparam int SAMPLE_W   = 12;
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = 4;
   localparam int FIFO_CNT_W = 5;   // Holds 0 to FIFO_DEPTH
   localparam int CMD_W      = 2;
   localparam int LOST_W     = 16;

   localparam logic [CMD_W-1:0]  CMD_SAMPLE   = 2'd0;
   localparam logic [CMD_W-1:0]  CMD_OVERFLOW = 2'd1;
   localparam logic [LOST_W-1:0] LOST_MAX     = 16'hffff;

   // One 18-bit FIFO word, decoded by its command field
   typedef union packed {
      struct packed {
         logic [CMD_W-1:0]    cmd;
         logic [3:0]          rsvd;     // Always zero
         logic [SAMPLE_W-1:0] sample;
      } sample_view;
      struct packed {
         logic [CMD_W-1:0]    cmd;
         logic [LOST_W-1:0]   lost;     // Samples dropped while full
      } overflow_view;
   } fifo_word_t;

endpackage

//--- hw/husky_capture_top.sv
module husky_capture_top
   import capture_pkg::*;
(
   input  logic                clk_usb_buf,
   input  logic                rst_n_i,
   input  logic [7:0]          usb_addr_i,
   input  logic [7:0]          usb_data_i,
   input  logic                usb_cen_n_i,
   input  logic                usb_wrn_i,
   input  logic                usb_rdn_i,
   input  logic [SAMPLE_W-1:0] sample_i,
   input  logic                sample_valid_i,
   output logic [7:0]          usb_data_o,
   output logic                led_armed_o,
   output logic                led_err_o
);

   logic                  arm;
   logic                  flush_pulse;
   logic                  pop;
   logic                  push;
   fifo_word_t            push_word;
   fifo_word_t            head_word;
   logic                  full;
   logic                  empty;
   logic [FIFO_CNT_W-1:0] count;
   logic                  sample_lost;
   logic                  error;

   // Producer side
   capture_packer u_capture_packer (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .arm_i          (arm),
      .sample_i       (sample_i),
      .sample_valid_i (sample_valid_i),
      .full_i         (full),
      .push_o         (push),
      .push_word_o    (push_word),
      .sample_lost_o  (sample_lost)
   );

   capture_fifo u_capture_fifo (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .push_i      (push),
      .push_word_i (push_word),
      .pop_i       (pop),
      .flush_i     (flush_pulse),
      .head_word_o (head_word),
      .count_o     (count),
      .empty_o     (empty),
      .full_o      (full)
   );

   // USB register bus side
   usb_reg_port u_usb_reg_port (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_cen_n_i   (usb_cen_n_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_rdn_i     (usb_rdn_i),
      .head_word_i   (head_word),
      .count_i       (count),
      .empty_i       (empty),
      .full_i        (full),
      .sample_lost_i (sample_lost),
      .usb_data_o    (usb_data_o),
      .arm_o         (arm),
      .flush_o       (flush_pulse),
      .pop_o         (pop),
      .error_o       (error)
   );

   status_leds u_status_leds (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .arm_i       (arm),
      .error_i     (error),
      .led_armed_o (led_armed_o),
      .led_err_o   (led_err_o)
   );

endmodule

//--- hw/status_leds.sv
module status_leds
   import usb_reg_pkg::*;
(
   input  logic clk_usb_buf,
   input  logic rst_n_i,
   input  logic arm_i,
   input  logic error_i,
   output logic led_armed_o,
   output logic led_err_o
);

   logic [FLASH_BIT:0] flash_cnt;   // Free running

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         flash_cnt <= '0;
      end else begin
         flash_cnt <= flash_cnt + 1'b1;
      end
   end

   assign led_armed_o = arm_i;
   // Flash only while the sticky error is set
   assign led_err_o   = error_i && flash_cnt[FLASH_BIT];

endmodule

//--- hw/usb_reg_pkg.sv
package usb_reg_pkg;

   // Register map
   localparam logic [7:0] REG_CTRL   = 8'h01;
   localparam logic [7:0] REG_STATUS = 8'h02;
   localparam logic [7:0] REG_FIFO   = 8'h03;   // Byte stream of the capture FIFO

   // Control register bits
   localparam int CTRL_ARM   = 0;   // Held level
   localparam int CTRL_FLUSH = 1;   // Pulse
   localparam int CTRL_CLEAR = 2;   // Pulse that clears the sticky error

   // Status register layout
   localparam int STAT_EMPTY   = 0;
   localparam int STAT_FULL    = 1;
   localparam int STAT_ERROR   = 2;
   localparam int STAT_CNT_LSB = 3;   // Word count in bits 7 to 3

   // LED counter bit that toggles the error flash every 8 cycles
   localparam int FLASH_BIT = 3;

endpackage

//--- hw/usb_reg_port.sv
module usb_reg_port
   import capture_pkg::*;
   import usb_reg_pkg::*;
(
   input  logic                  clk_usb_buf,
   input  logic                  rst_n_i,
   input  logic [7:0]            usb_addr_i,
   input  logic [7:0]            usb_data_i,
   input  logic                  usb_cen_n_i,
   input  logic                  usb_wrn_i,
   input  logic                  usb_rdn_i,
   input  fifo_word_t            head_word_i,
   input  logic [FIFO_CNT_W-1:0] count_i,
   input  logic                  empty_i,
   input  logic                  full_i,
   input  logic                  sample_lost_i,
   output logic [7:0]            usb_data_o,
   output logic                  arm_o,
   output logic                  flush_o,
   output logic                  pop_o,
   output logic                  error_o
);

   logic       wr_en;
   logic       rd_en;
   logic       wr_ctrl;
   logic       clear;
   logic       fifo_rd;
   logic [1:0] byte_idx;   // Next byte of the head word
   logic [7:0] status_byte;
   logic [7:0] fifo_byte;
   logic [7:0] rd_data;

   assign wr_en   = !usb_cen_n_i && !usb_wrn_i;
   assign rd_en   = !usb_cen_n_i && !usb_rdn_i;
   assign wr_ctrl = wr_en && (usb_addr_i == REG_CTRL);
   assign flush_o = wr_ctrl && usb_data_i[CTRL_FLUSH];
   assign clear   = wr_ctrl && usb_data_i[CTRL_CLEAR];
   assign fifo_rd = rd_en && (usb_addr_i == REG_FIFO) && !empty_i;
   assign pop_o   = fifo_rd && (byte_idx == 2'd2);   // Last byte releases the word

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         arm_o   <= 1'b0;
         error_o <= 1'b0;
      end else begin
         if (wr_ctrl) arm_o <= usb_data_i[CTRL_ARM];
         // A new loss outranks a clear in the same cycle
         if (sample_lost_i) error_o <= 1'b1;
         else if (clear) error_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) byte_idx <= '0;
      else if (flush_o) byte_idx <= '0;
      else if (fifo_rd) byte_idx <= pop_o ? 2'd0 : byte_idx + 2'd1;
   end

   always_comb begin
      status_byte                               = '0;
      status_byte[STAT_EMPTY]                   = empty_i;
      status_byte[STAT_FULL]                    = full_i;
      status_byte[STAT_ERROR]                   = error_o;
      status_byte[STAT_CNT_LSB +: FIFO_CNT_W]   = count_i;
   end

   // Payload bits are shared by both word views
   always_comb begin
      case (byte_idx)
         2'd0:    fifo_byte = head_word_i.overflow_view.lost[7:0];
         2'd1:    fifo_byte = head_word_i.overflow_view.lost[15:8];
         default: fifo_byte = 8'(head_word_i.overflow_view.cmd);
      endcase
   end

   always_comb begin
      rd_data = '0;
      case (usb_addr_i)
         REG_CTRL:   rd_data[CTRL_ARM] = arm_o;
         REG_STATUS: rd_data = status_byte;
         REG_FIFO:   if (!empty_i) rd_data = fifo_byte;
         default:    rd_data = '0;   // Unknown address
      endcase
   end

   // Read data shows up one cycle after the strobe and holds
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) usb_data_o <= '0;
      else if (rd_en) usb_data_o <= rd_data;
   end

endmodule

//--- verification/husky_capture_assertions.sv
module husky_capture_assertions
   import capture_pkg::*;
(
   input logic                  clk_usb_buf,
   input logic                  rst_n_i,
   input logic                  push_i,
   input logic                  full_i,
   input logic [FIFO_CNT_W-1:0] count_i,
   input logic                  error_i,
   input logic                  led_err_i
);

   // Packer holds back while the FIFO is full
   push_while_full: assert property (
      @(posedge clk_usb_buf) disable iff (!rst_n_i) !(push_i && full_i)
   ) else $error("FIFO push while full");

   count_in_range: assert property (
      @(posedge clk_usb_buf) disable iff (!rst_n_i) count_i <= FIFO_CNT_W'(FIFO_DEPTH)
   ) else $error("FIFO count above depth");

   led_dark_without_error: assert property (
      @(posedge clk_usb_buf) disable iff (!rst_n_i) !error_i |-> !led_err_i
   ) else $error("Error LED lit while error is clear");

endmodule

bind husky_capture_top husky_capture_assertions u_husky_capture_assertions (
   .clk_usb_buf (clk_usb_buf),
   .rst_n_i     (rst_n_i),
   .push_i      (push),
   .full_i      (full),
   .count_i     (count),
   .error_i     (error),
   .led_err_i   (led_err_o)
);

//--- verification/tb_husky_capture.sv
module tb_husky_capture
   import capture_pkg::*;
   import usb_reg_pkg::*;
();

   localparam logic [2:0] OP_IDLE  = 3'd0;
   localparam logic [2:0] OP_WR    = 3'd1;
   localparam logic [2:0] OP_RD    = 3'd2;
   localparam logic [2:0] OP_BURST = 3'd3;
   localparam logic [2:0] OP_LEDS  = 3'd4;   // exp_byte = {arm mixed, err low, err high, armed}
   localparam int         NROWS    = 34;

   typedef struct packed {
      logic [2:0] op;
      logic [7:0] addr;
      logic [7:0] data;
      logic [7:0] rep;
      logic [7:0] exp_byte;
      logic       from_model;   // Expected byte taken from the model queue
   } row_t;

   logic                clk_usb_buf;
   logic                rst_n;
   logic [7:0]          usb_addr;
   logic [7:0]          usb_data_in;
   logic                usb_cen_n;
   logic                usb_wrn;
   logic                usb_rdn;
   logic [SAMPLE_W-1:0] sample;
   logic                sample_valid;
   logic [7:0]          usb_data_out;
   logic                led_armed;
   logic                led_err;

   row_t        rows [NROWS];
   logic [17:0] model_q [$];   // {cmd, 16-bit payload}
   int          model_idx   = 0;
   logic [15:0] model_lost  = '0;
   logic        model_arm   = 1'b0;
   int          err_cnt     = 0;
   int          timeout_cnt = 0;
   int          cycle_cnt   = 0;
   int          cycle_limit = 0;

   husky_capture_top u_husky_capture_top (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n),
      .usb_addr_i     (usb_addr),
      .usb_data_i     (usb_data_in),
      .usb_cen_n_i    (usb_cen_n),
      .usb_wrn_i      (usb_wrn),
      .usb_rdn_i      (usb_rdn),
      .sample_i       (sample),
      .sample_valid_i (sample_valid),
      .usb_data_o     (usb_data_out),
      .led_armed_o    (led_armed),
      .led_err_o      (led_err)
   );

   initial clk_usb_buf = 1'b0;
   always #20 clk_usb_buf = ~clk_usb_buf;

   task automatic report_counts();
      $display("Summary: %0d value errors, %0d timeouts", err_cnt, timeout_cnt);
   endtask

   always @(posedge clk_usb_buf) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         timeout_cnt = timeout_cnt + 1;
         $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
         report_counts();
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic check_byte(input logic [7:0] addr, input logic [7:0] got,
                             input logic [7:0] exp_b);
      assert (got === exp_b) else begin
         err_cnt++;
         $display("Error at %0t: addr %02h read %02h, expected %02h", $time, addr, got, exp_b);
      end
   endtask

   // Next stream byte as the bus should return it with the low byte first
   task automatic model_fifo_byte(output logic [7:0] exp_b);
      logic [17:0] w;
      exp_b = 8'h00;
      if (model_q.size() != 0) begin
         w = model_q[0];
         case (model_idx)
            0:       exp_b = w[7:0];
            1:       exp_b = w[15:8];
            default: exp_b = {6'b0, w[17:16]};
         endcase
         if (model_idx == 2) begin
            void'(model_q.pop_front());
            model_idx = 0;
            if (model_lost != '0) begin   // Marker goes in once there is space again
               model_q.push_back({CMD_OVERFLOW, model_lost});
               model_lost = '0;
            end
         end else begin
            model_idx++;
         end
      end
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      usb_addr    = addr;
      usb_data_in = data;
      usb_cen_n   = 1'b0;
      usb_wrn     = 1'b0;
      @(negedge clk_usb_buf);
      usb_cen_n = 1'b1;
      usb_wrn   = 1'b1;
      if (addr == REG_CTRL) begin
         model_arm = data[CTRL_ARM];
         if (data[CTRL_FLUSH]) begin
            model_q.delete();
            model_idx = 0;
            if (model_lost != '0) begin
               model_q.push_back({CMD_OVERFLOW, model_lost});
               model_lost = '0;
            end
         end
      end
   endtask

   task automatic bus_read(input logic [7:0] addr, input logic from_model,
                           input logic [7:0] tbl_exp);
      logic [7:0] exp_b;
      logic [7:0] model_exp;
      exp_b = tbl_exp;
      if (addr == REG_FIFO) begin
         model_fifo_byte(model_exp);
         if (from_model) exp_b = model_exp;
      end
      usb_addr  = addr;
      usb_cen_n = 1'b0;
      usb_rdn   = 1'b0;
      @(negedge clk_usb_buf);
      usb_cen_n = 1'b1;
      usb_rdn   = 1'b1;
      check_byte(addr, usb_data_out, exp_b);   // Registered one cycle after the strobe
   endtask

   task automatic sample_burst(input int n);
      logic [SAMPLE_W-1:0] smp;
      for (int k = 0; k < n; k++) begin
         smp          = SAMPLE_W'($urandom());
         sample       = smp;
         sample_valid = 1'b1;
         if (model_arm) begin
            if (model_q.size() < FIFO_DEPTH) model_q.push_back({CMD_SAMPLE, 4'b0, smp});
            else if (model_lost != LOST_MAX) model_lost++;
         end
         @(negedge clk_usb_buf);
      end
      sample_valid = 1'b0;
   endtask

   task automatic watch_leds(input int n, input logic [7:0] exp_b);
      logic err_hi;
      logic err_lo;
      logic arm_hi;
      logic arm_lo;
      err_hi = 1'b0;
      err_lo = 1'b0;
      arm_hi = 1'b0;
      arm_lo = 1'b0;
      repeat (n) begin
         @(negedge clk_usb_buf);
         if (led_err) err_hi = 1'b1;
         else err_lo = 1'b1;
         if (led_armed) arm_hi = 1'b1;
         else arm_lo = 1'b1;
      end
      check_byte(8'h00, {4'b0, arm_hi && arm_lo, err_lo, err_hi, arm_hi}, exp_b);
   endtask

   initial begin
      int total;
      void'($urandom(32'hc37144a9));
      rst_n        = 1'b0;
      usb_addr     = '0;
      usb_data_in  = '0;
      usb_cen_n    = 1'b1;
      usb_wrn      = 1'b1;
      usb_rdn      = 1'b1;
      sample       = '0;
      sample_valid = 1'b0;
      rows = '{
         '{OP_RD,    REG_STATUS, 8'h00, 8'd1,  8'h01, 1'b0},   // Empty after reset
         '{OP_LEDS,  8'h00,      8'h00, 8'd16, 8'h04, 1'b0},
         '{OP_WR,    REG_CTRL,   8'h01, 8'd1,  8'h00, 1'b0},   // Arm
         '{OP_BURST, 8'h00,      8'h00, 8'd3,  8'h00, 1'b0},
         '{OP_IDLE,  8'h00,      8'h00, 8'd2,  8'h00, 1'b0},
         '{OP_RD,    REG_FIFO,   8'h00, 8'd9,  8'h00, 1'b1},
         '{OP_RD,    REG_STATUS, 8'h00, 8'd1,  8'h01, 1'b0},
         '{OP_WR,    REG_CTRL,   8'h00, 8'd1,  8'h00, 1'b0},   // Disarm
         '{OP_BURST, 8'h00,      8'h00, 8'd4,  8'h00, 1'b0},
         '{OP_IDLE,  8'h00,      8'h00, 8'd2,  8'h00, 1'b0},
         '{OP_RD,    REG_STATUS, 8'h00, 8'd1,  8'h01, 1'b0},
         '{OP_RD,    REG_CTRL,   8'h00, 8'd1,  8'h00, 1'b0},
         '{OP_RD,    8'h7f,      8'h00, 8'd1,  8'h00, 1'b0},   // Unmapped
         '{OP_WR,    REG_CTRL,   8'h01, 8'd1,  8'h00, 1'b0},
         '{OP_BURST, 8'h00,      8'h00, 8'd21, 8'h00, 1'b0},   // Overruns by 5
         '{OP_IDLE,  8'h00,      8'h00, 8'd2,  8'h00, 1'b0},
         '{OP_RD,    REG_STATUS, 8'h00, 8'd1,  8'h86, 1'b0},
         '{OP_LEDS,  8'h00,      8'h00, 8'd16, 8'h07, 1'b0},
         '{OP_RD,    REG_FIFO,   8'h00, 8'd51, 8'h00, 1'b1},   // 16 samples and the marker
         '{OP_RD,    REG_STATUS, 8'h00, 8'd1,  8'h05, 1'b0},
         '{OP_RD,    REG_FIFO,   8'h00, 8'd1,  8'h00, 1'b1},
         '{OP_BURST, 8'h00,      8'h00, 8'd4,  8'h00, 1'b0},
         '{OP_IDLE,  8'h00,      8'h00, 8'd2,  8'h00, 1'b0},
         '{OP_RD,    REG_STATUS, 8'h00, 8'd1,  8'h24, 1'b0},
         '{OP_RD,    REG_FIFO,   8'h00, 8'd1,  8'h00, 1'b1},   // Leaves byte index at 1
         '{OP_WR,    REG_CTRL,   8'h03, 8'd1,  8'h00, 1'b0},   // Flush and stay armed
         '{OP_RD,    REG_STATUS, 8'h00, 8'd1,  8'h05, 1'b0},
         '{OP_BURST, 8'h00,      8'h00, 8'd1,  8'h00, 1'b0},
         '{OP_IDLE,  8'h00,      8'h00, 8'd2,  8'h00, 1'b0},
         '{OP_RD,    REG_FIFO,   8'h00, 8'd3,  8'h00, 1'b1},
         '{OP_WR,    REG_CTRL,   8'h05, 8'd1,  8'h00, 1'b0},   // Clear error
         '{OP_RD,    REG_STATUS, 8'h00, 8'd1,  8'h01, 1'b0},
         '{OP_LEDS,  8'h00,      8'h00, 8'd16, 8'h05, 1'b0},
         '{OP_RD,    REG_CTRL,   8'h00, 8'd1,  8'h01, 1'b0}
      };
      total = 0;
      foreach (rows[r]) total += int'(rows[r].rep);
      cycle_limit = total * 4 + 200;

      repeat (8) @(negedge clk_usb_buf);
      rst_n = 1'b1;
      @(negedge clk_usb_buf);

      foreach (rows[r]) begin
         case (rows[r].op)
            OP_WR:    repeat (rows[r].rep) bus_write(rows[r].addr, rows[r].data);
            OP_RD:    repeat (rows[r].rep) bus_read(rows[r].addr, rows[r].from_model,
                                                    rows[r].exp_byte);
            OP_BURST: sample_burst(int'(rows[r].rep));
            OP_LEDS:  watch_leds(int'(rows[r].rep), rows[r].exp_byte);
            default:  repeat (rows[r].rep) @(negedge clk_usb_buf);
         endcase
      end

      repeat (2) @(negedge clk_usb_buf);
      report_counts();
      if (err_cnt == 0 && timeout_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- verilog.f
hw/capture_pkg.sv
hw/usb_reg_pkg.sv
hw/capture_packer.sv
hw/capture_fifo.sv
hw/usb_reg_port.sv
hw/status_leds.sv
hw/husky_capture_top.sv
verification/husky_capture_assertions.sv
verification/tb_husky_capture.sv
